//--- Makefile
TOOL     = verilator
TOP      = tb_csr_unit
FILELIST = verilog.f
FLAGS    = --binary --timing --top-module $(TOP)
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run, and look for the pass line in $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- cpu_pkg.sv
package cpu_pkg;

	// zicsr access flavour, low bits of funct3
	typedef enum logic [1:0] {
		CSR_RD = 2'd0,	// read only, no write side effect
		CSR_RW = 2'd1,
		CSR_RS = 2'd2,	// set bits
		CSR_RC = 2'd3	// clear bits
	} csr_op_t;

	// what the core is asking for
	typedef enum logic [1:0] {
		CMD_ACCESS = 2'd0,
		CMD_TRAP   = 2'd1,	// trap entry
		CMD_MRET   = 2'd2	// return from trap
	} csr_cmd_t;

	// mcause word
	typedef struct packed {
		logic        interrupt;	// 1 for async cause
		logic [30:0] code;	// exception or interrupt code
	} mcause_t;

	// floating point csrs
	localparam logic [11:0] CSR_ADDR_FFLAGS = 12'h001;
	localparam logic [11:0] CSR_ADDR_FRM    = 12'h002;
	localparam logic [11:0] CSR_ADDR_FCSR   = 12'h003;

	// machine trap setup
	localparam logic [11:0] CSR_ADDR_MSTATUS       = 12'h300;
	localparam logic [11:0] CSR_ADDR_MISA          = 12'h301;
	localparam logic [11:0] CSR_ADDR_MIE           = 12'h304;
	localparam logic [11:0] CSR_ADDR_MTVEC         = 12'h305;
	localparam logic [11:0] CSR_ADDR_MSTATUSH      = 12'h310;
	localparam logic [11:0] CSR_ADDR_MCOUNTINHIBIT = 12'h320;

	// machine trap handling
	localparam logic [11:0] CSR_ADDR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_ADDR_MEPC     = 12'h341;
	localparam logic [11:0] CSR_ADDR_MCAUSE   = 12'h342;
	localparam logic [11:0] CSR_ADDR_MTVAL    = 12'h343;
	localparam logic [11:0] CSR_ADDR_MIP      = 12'h344;

	// machine counters
	localparam logic [11:0] CSR_ADDR_MCYCLE    = 12'hB00;
	localparam logic [11:0] CSR_ADDR_MINSTRET  = 12'hB02;
	localparam logic [11:0] CSR_ADDR_MCYCLEH   = 12'hB80;
	localparam logic [11:0] CSR_ADDR_MINSTRETH = 12'hB82;

	// machine information, read-only space
	localparam logic [11:0] CSR_ADDR_MVENDORID  = 12'hF11;
	localparam logic [11:0] CSR_ADDR_MARCHID    = 12'hF12;
	localparam logic [11:0] CSR_ADDR_MIMPID     = 12'hF13;
	localparam logic [11:0] CSR_ADDR_MHARTID    = 12'hF14;
	localparam logic [11:0] CSR_ADDR_MCONFIGPTR = 12'hF15;

endpackage

//--- csr_access_ctrl.sv
`timescale 1ns/1ps

module csr_access_ctrl import cpu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        req,
	output logic        ack,
	input  csr_cmd_t    cmd,
	input  csr_op_t     op,
	input  logic [11:0] addr,
	input  logic [31:0] wdata,
	input  mcause_t     cause,
	input  logic [31:0] epc,
	input  logic [31:0] tval,
	output logic [31:0] rdata,
	output logic        illegal,
	output logic [31:0] redirect_pc,
	csr_bus_if.ctrl     bus
);

	localparam logic [1:0] S_IDLE  = 2'd0;	// waiting for req
	localparam logic [1:0] S_ISSUE = 2'd1;	// strobe cycle
	localparam logic [1:0] S_ACK   = 2'd2;	// ack high until req drops

	logic [1:0] state;

	// core holds the fields stable until ack so they go straight onto the bus
	assign bus.cmd   = cmd;
	assign bus.op    = op;
	assign bus.addr  = addr;
	assign bus.wdata = wdata;
	assign bus.cause = cause;
	assign bus.epc   = epc;
	assign bus.tval  = tval;

	assign bus.strobe = (state == S_ISSUE);
	assign ack        = (state == S_ACK);	// registered through state

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:  if (req) state <= S_ISSUE;
				S_ISSUE: state <= S_ACK;	// file commits on this edge
				S_ACK:   if (!req) state <= S_IDLE;	// return to zero
				default: state <= S_IDLE;
			endcase
		end
	end

	// response held for the whole ack phase
	always_ff @(posedge clk) begin
		if (state == S_ISSUE) begin
			rdata   <= bus.rdata;	// old value
			illegal <= bus.illegal;
			case (cmd)
				CMD_TRAP: redirect_pc <= bus.trap_pc;
				CMD_MRET: redirect_pc <= bus.ret_pc;
				default:  redirect_pc <= 32'h0;	// plain access has no redirect
			endcase
		end
	end

endmodule

//--- csr_bus_if.sv
`timescale 1ns/1ps

interface csr_bus_if import cpu_pkg::*; ();

	logic        strobe;	// one cycle per request
	csr_cmd_t    cmd;
	csr_op_t     op;
	logic [11:0] addr;
	logic [31:0] wdata;
	mcause_t     cause;	// trap only
	logic [31:0] epc;	// trap only
	logic [31:0] tval;	// trap only

	logic [31:0] rdata;	// value before the write
	logic        illegal;
	logic [31:0] trap_pc;	// vector target from mtvec
	logic [31:0] ret_pc;	// mepc

	modport ctrl (
		output strobe, cmd, op, addr, wdata, cause, epc, tval,
		input  rdata, illegal, trap_pc, ret_pc
	);

	modport file (
		input  strobe, cmd, op, addr, wdata, cause, epc, tval,
		output rdata, illegal, trap_pc, ret_pc
	);

endinterface

//--- csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// M extension present, sets misa bit 12
`define CSR_M_EXT 1'b1

// F extension present, sets misa bit 5 and enables fflags/frm/fcsr
`define CSR_F_EXT 1'b1

// value seen in mhartid
`define CSR_HART_ID 32'h0000_0000

`endif

//--- csr_checker.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_checker import cpu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        req,
	input  logic        ack,
	input  logic [1:0]  cmd,
	input  logic [1:0]  op,
	input  logic [11:0] addr,
	input  logic [31:0] wdata, cause, epc, tval,
	input  logic [31:0] rdata,
	input  logic        illegal,
	input  logic [31:0] redirect_pc,
	input  logic        retire,
	input  logic [2:0]  irq_lines,
	input  logic        irq_pending,
	output int          errors
);

	logic        mie_b, mpie_b, cy_inh, ir_inh, do_wr, wr, bad, exp_irq;
	logic [1:0]  fs;
	logic [2:0]  phase;	// 0 idle 1 commit edge 2 first ack edge 3 ack held 4 ack falling
	logic [7:0]  fcsr;	// frm over fflags
	logic [31:0] tvec, ien, scratch, mepc, mcause, mtval, nv, exp_pc;
	logic [32:0] r, exp_rd;	// flag over value
	logic [63:0] cyc, ins, cyc_pre, ins_pre;

	// {implemented, value} straight from the register rules
	function automatic logic [32:0] read_csr(input logic [11:0] a);
		case (a)
			CSR_ADDR_MISA:
				return {1'b1, 32'h4000_0100 | {19'h0, `CSR_M_EXT, 6'h0, `CSR_F_EXT, 5'h0}};
			CSR_ADDR_MVENDORID, CSR_ADDR_MARCHID, CSR_ADDR_MIMPID, CSR_ADDR_MCONFIGPTR,
			CSR_ADDR_MSTATUSH:      return {1'b1, 32'h0};
			CSR_ADDR_MHARTID:       return {1'b1, `CSR_HART_ID};
			CSR_ADDR_MSTATUS:
				return {1'b1, fs == 2'b11, 16'h0, fs, 2'b11, 3'b0, mpie_b, 3'b0, mie_b, 3'b0};
			CSR_ADDR_MTVEC:         return {1'b1, tvec};
			CSR_ADDR_MIP:
				return {1'b1, 20'h0, irq_lines[2], 3'b0, irq_lines[1], 3'b0, irq_lines[0], 3'b0};
			CSR_ADDR_MIE:           return {1'b1, ien};
			CSR_ADDR_MCYCLE:        return {1'b1, cyc[31:0]};
			CSR_ADDR_MCYCLEH:       return {1'b1, cyc[63:32]};
			CSR_ADDR_MINSTRET:      return {1'b1, ins[31:0]};
			CSR_ADDR_MINSTRETH:     return {1'b1, ins[63:32]};
			CSR_ADDR_MCOUNTINHIBIT: return {1'b1, 29'h0, ir_inh, 1'b0, cy_inh};
			CSR_ADDR_MSCRATCH:      return {1'b1, scratch};
			CSR_ADDR_MEPC:          return {1'b1, mepc};
			CSR_ADDR_MCAUSE:        return {1'b1, mcause};
			CSR_ADDR_MTVAL:         return {1'b1, mtval};
			CSR_ADDR_FFLAGS:        return {`CSR_F_EXT, 27'h0, fcsr[4:0]};
			CSR_ADDR_FRM:           return {`CSR_F_EXT, 29'h0, fcsr[7:5]};
			CSR_ADDR_FCSR:          return {`CSR_F_EXT, 24'h0, fcsr};
			default:                return 33'h0;	// unimplemented
		endcase
	endfunction

	task automatic write_csr(input logic [11:0] a, input logic [31:0] v);
		case (a)
			CSR_ADDR_MSTATUS: begin
				mie_b  = v[3];
				mpie_b = v[7];
				fs     = `CSR_F_EXT ? v[14:13] : 2'b00;
			end
			CSR_ADDR_MIE:           ien = v & 32'h0000_0888;
			CSR_ADDR_MTVEC:         tvec = v & 32'hFFFF_FFFD;	// mode bit 1 gone
			CSR_ADDR_MSCRATCH:      scratch = v;
			CSR_ADDR_MEPC:          mepc = v & 32'hFFFF_FFFC;
			CSR_ADDR_MCAUSE:        mcause = v;
			CSR_ADDR_MTVAL:         mtval = v;
			CSR_ADDR_MCOUNTINHIBIT: {ir_inh, cy_inh} = {v[2], v[0]};
			CSR_ADDR_MCYCLE:        cyc = {cyc_pre[63:32], v};	// write beats increment
			CSR_ADDR_MCYCLEH:       cyc = {v, cyc_pre[31:0]};
			CSR_ADDR_MINSTRET:      ins = {ins_pre[63:32], v};
			CSR_ADDR_MINSTRETH:     ins = {v, ins_pre[31:0]};
			CSR_ADDR_FFLAGS:        {fs, fcsr[4:0]} = {2'b11, v[4:0]};	// fs dirty
			CSR_ADDR_FRM:           {fs, fcsr[7:5]} = {2'b11, v[2:0]};
			CSR_ADDR_FCSR:          {fs, fcsr} = {2'b11, v[7:0]};
			default: ;
		endcase
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
		errors++;
	endtask

	task automatic handshake_fault(input string msg);
		$display("handshake fault at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic compare_response();
		logic [32:0] ip;
		ip      = read_csr(CSR_ADDR_MIP);
		exp_irq = mie_b && |(ien & ip[31:0]);
		if (cmd == CMD_ACCESS && rdata !== exp_rd[31:0])
			report_mismatch("rdata", rdata, exp_rd[31:0]);
		if (illegal !== exp_rd[32])
			report_mismatch("illegal", 32'(illegal), 32'(exp_rd[32]));
		if (redirect_pc !== exp_pc)
			report_mismatch("redirect_pc", redirect_pc, exp_pc);
		if (irq_pending !== exp_irq)
			report_mismatch("irq_pending", 32'(irq_pending), 32'(exp_irq));
	endtask

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			{mie_b, mpie_b, cy_inh, ir_inh, fs, fcsr} = '0;
			{tvec, ien, scratch, mepc, mcause, mtval} = '0;
			{cyc, ins} = '0;
			phase  = 3'd0;
			errors = 0;
		end else begin
			do_wr   = 1'b0;
			cyc_pre = cyc;
			ins_pre = ins;
			case (phase)
				3'd0: begin
					if (ack)
						handshake_fault("ack rose while no request was pending");
					if (req)
						phase = 3'd1;	// sampled in idle
				end
				3'd1: begin	// the dut commits on this edge
					if (ack)
						handshake_fault("ack rose before the strobe cycle ended");
					r      = read_csr(addr);
					wr     = (cmd == CMD_ACCESS) && (op != CSR_RD);
					bad    = (cmd == CMD_ACCESS) && (!r[32] || (wr && addr[11:10] == 2'b11));
					exp_rd = {bad, r[31:0]};
					case (op)
						CSR_RS:  nv = r[31:0] | wdata;
						CSR_RC:  nv = r[31:0] & ~wdata;
						default: nv = wdata;
					endcase
					do_wr  = wr && !bad;
					exp_pc = 32'h0;
					if (cmd == CMD_TRAP) begin
						exp_pc = {tvec[31:2], 2'b00};
						if (cause[31] && tvec[0])
							exp_pc = exp_pc + (cause << 2);	// vectored interrupt
						mepc   = epc;
						mcause = cause;
						mtval  = tval;
						mpie_b = mie_b;
						mie_b  = 1'b0;
					end else if (cmd == CMD_MRET) begin
						exp_pc = mepc;
						mie_b  = mpie_b;
						mpie_b = 1'b1;
					end
					phase = 3'd2;
				end
				3'd2, 3'd3: begin
					if (!ack)
						handshake_fault("ack was low two cycles after req or before req fell");
					else if (phase == 3'd2)
						compare_response();
					phase = req ? 3'd3 : 3'd4;
				end
				default: begin
					if (ack)
						handshake_fault("ack still high one cycle after req fell");
					phase = 3'd0;
				end
			endcase
			if (!cy_inh)
				cyc = cyc + 64'd1;
			if (retire && !ir_inh)
				ins = ins + 64'd1;
			if (do_wr)
				write_csr(addr, nv);
		end
	end

endmodule

//--- csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
	input  logic        clk,
	input  logic        reset,
	input  logic        retire,	// one pulse per retired instr
	input  logic        cy_inhibit,
	input  logic        ir_inhibit,
	input  logic        wr_en,
	input  logic [1:0]  wr_sel,	// bit 1 picks instret and bit 0 the high half
	input  logic [31:0] wr_data,
	output logic [63:0] mcycle,
	output logic [63:0] minstret
);

	logic [63:0] cnt [2];	// 0 is mcycle and 1 is minstret
	logic [1:0]  inc;

	assign inc[0] = !cy_inhibit;	// every clock
	assign inc[1] = retire && !ir_inhibit;

	for (genvar i = 0; i < 2; i++) begin : g_cnt
		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				cnt[i] <= 64'h0;
			end else if (wr_en && (wr_sel[1] == i[0])) begin
				// half-word write wins over the increment
				if (wr_sel[0])
					cnt[i][63:32] <= wr_data;
				else
					cnt[i][31:0] <= wr_data;
			end else if (inc[i]) begin
				cnt[i] <= cnt[i] + 64'd1;
			end
		end
	end

	assign mcycle   = cnt[0];
	assign minstret = cnt[1];

endmodule

//--- csr_file.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_file import cpu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       retire,
	input  logic [2:0] irq_lines,	// [0] software [1] timer [2] external
	output logic       irq_pending,
	csr_bus_if.file    bus
);

	// mstatus fields that hold state
	logic        st_mie;
	logic        st_mpie;
	logic [1:0]  st_fs;	// float unit status
	logic [31:0] mstatus;

	logic [31:2] tvec_base;
	logic        tvec_mode;	// only vectored bit kept
	logic [31:0] mtvec;

	logic [31:0] mie;
	logic [31:0] mip;
	logic [31:0] mscratch;
	logic [31:0] mepc;
	mcause_t     mcause;
	logic [31:0] mtval;
	logic [4:0]  fflags;
	logic [2:0]  frm;
	logic        cy_inh;
	logic        ir_inh;
	logic [63:0] mcycle;
	logic [63:0] minstret;
	logic [31:0] misa;

	logic [31:0] old_val;	// read mux output
	logic        hit;	// address implemented
	logic        is_access;
	logic        wr_req;	// access that wants to write
	logic        ro_space;	// addr[11:10] == 3
	logic        illegal_c;
	logic [31:0] new_val;	// read-modify-write result
	logic        we;
	logic        cnt_we;
	logic [1:0]  cnt_sel;

	assign misa = {2'b01, 4'b0, 13'b0, `CSR_M_EXT, 6'b000100, `CSR_F_EXT, 5'b0};	// rv32 I

	assign mstatus = {
		(st_fs == 2'b11),	// sd summary bit
		14'b0,
		2'b00,		// xs
		st_fs,		// 14:13
		2'b11,		// mpp always machine
		3'b0,
		st_mpie,	// 7
		3'b0,
		st_mie,		// 3
		3'b0
	};

	assign mtvec = {tvec_base, 1'b0, tvec_mode};
	assign mip   = {20'b0, irq_lines[2], 3'b0, irq_lines[1], 3'b0, irq_lines[0], 3'b0};

	assign irq_pending = st_mie && |(mip & mie);

	// zero latency read
	always_comb begin
		old_val = 32'h0;
		hit     = 1'b1;
		case (bus.addr)
			CSR_ADDR_MISA:          old_val = misa;
			CSR_ADDR_MVENDORID:     old_val = 32'h0;	// non-commercial
			CSR_ADDR_MARCHID:       old_val = 32'h0;
			CSR_ADDR_MIMPID:        old_val = 32'h0;
			CSR_ADDR_MHARTID:       old_val = `CSR_HART_ID;
			CSR_ADDR_MCONFIGPTR:    old_val = 32'h0;
			CSR_ADDR_MSTATUS:       old_val = mstatus;
			CSR_ADDR_MSTATUSH:      old_val = 32'h0;	// little endian only
			CSR_ADDR_MTVEC:         old_val = mtvec;
			CSR_ADDR_MIP:           old_val = mip;
			CSR_ADDR_MIE:           old_val = mie;
			CSR_ADDR_MCYCLE:        old_val = mcycle[31:0];
			CSR_ADDR_MCYCLEH:       old_val = mcycle[63:32];
			CSR_ADDR_MINSTRET:      old_val = minstret[31:0];
			CSR_ADDR_MINSTRETH:     old_val = minstret[63:32];
			CSR_ADDR_MCOUNTINHIBIT: old_val = {29'b0, ir_inh, 1'b0, cy_inh};
			CSR_ADDR_MSCRATCH:      old_val = mscratch;
			CSR_ADDR_MEPC:          old_val = mepc;
			CSR_ADDR_MCAUSE:        old_val = mcause;
			CSR_ADDR_MTVAL:         old_val = mtval;
			CSR_ADDR_FFLAGS: begin
				old_val = {27'b0, fflags};
				hit     = `CSR_F_EXT;	// absent without F
			end
			CSR_ADDR_FRM: begin
				old_val = {29'b0, frm};
				hit     = `CSR_F_EXT;
			end
			CSR_ADDR_FCSR: begin
				old_val = {24'b0, frm, fflags};
				hit     = `CSR_F_EXT;
			end
			default:                hit = 1'b0;
		endcase
		if (!hit)
			old_val = 32'h0;	// unimplemented reads 0
	end

	assign is_access = (bus.cmd == CMD_ACCESS);
	assign wr_req    = is_access && (bus.op != CSR_RD);
	assign ro_space  = (bus.addr[11:10] == 2'b11);
	assign illegal_c = is_access && (!hit || (wr_req && ro_space));
	assign we        = bus.strobe && wr_req && !illegal_c;

	always_comb begin
		case (bus.op)
			CSR_RW:  new_val = bus.wdata;
			CSR_RS:  new_val = old_val | bus.wdata;
			CSR_RC:  new_val = old_val & ~bus.wdata;
			default: new_val = old_val;
		endcase
	end

	assign bus.rdata   = old_val;
	assign bus.illegal = illegal_c;
	assign bus.ret_pc  = mepc;
	// vectored mode only for interrupts
	assign bus.trap_pc = (bus.cause.interrupt && tvec_mode) ?
		{tvec_base, 2'b00} + {bus.cause.code[29:0], 2'b00} : {tvec_base, 2'b00};

	// counter half-word select from address bits
	assign cnt_we  = we && (bus.addr == CSR_ADDR_MCYCLE || bus.addr == CSR_ADDR_MCYCLEH ||
		bus.addr == CSR_ADDR_MINSTRET || bus.addr == CSR_ADDR_MINSTRETH);
	assign cnt_sel = {bus.addr[1], bus.addr[7]};	// instret / high half

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			st_mie    <= 1'b0;
			st_mpie   <= 1'b0;
			st_fs     <= 2'b00;
			tvec_base <= 30'h0;
			tvec_mode <= 1'b0;
			mie       <= 32'h0;
			mscratch  <= 32'h0;
			mepc      <= 32'h0;
			mcause    <= '0;
			mtval     <= 32'h0;
			fflags    <= 5'h0;
			frm       <= 3'h0;
			cy_inh    <= 1'b0;
			ir_inh    <= 1'b0;
		end else if (bus.strobe) begin
			case (bus.cmd)
				CMD_TRAP: begin
					mepc    <= bus.epc;
					mcause  <= bus.cause;
					mtval   <= bus.tval;
					st_mpie <= st_mie;	// stack the enable
					st_mie  <= 1'b0;
				end
				CMD_MRET: begin
					st_mie  <= st_mpie;
					st_mpie <= 1'b1;
				end
				default: if (we) begin
					case (bus.addr)
						CSR_ADDR_MSTATUS: begin
							st_mie  <= new_val[3];
							st_mpie <= new_val[7];
							st_fs   <= `CSR_F_EXT ? new_val[14:13] : 2'b00;
						end
						CSR_ADDR_MIE:      mie <= new_val & 32'h0000_0888;	// msie mtie meie
						CSR_ADDR_MTVEC: begin
							tvec_base <= new_val[31:2];
							tvec_mode <= new_val[0];	// bit 1 dropped
						end
						CSR_ADDR_MSCRATCH: mscratch <= new_val;
						CSR_ADDR_MEPC:     mepc <= {new_val[31:2], 2'b00};	// ialign 32
						CSR_ADDR_MCAUSE:   mcause <= new_val;
						CSR_ADDR_MTVAL:    mtval <= new_val;
						CSR_ADDR_MCOUNTINHIBIT: begin
							cy_inh <= new_val[0];
							ir_inh <= new_val[2];
						end
						CSR_ADDR_FFLAGS: begin
							fflags <= new_val[4:0];
							st_fs  <= 2'b11;	// dirty
						end
						CSR_ADDR_FRM: begin
							frm   <= new_val[2:0];
							st_fs <= 2'b11;
						end
						CSR_ADDR_FCSR: begin
							frm    <= new_val[7:5];
							fflags <= new_val[4:0];
							st_fs  <= 2'b11;
						end
						default: ;	// misa mip mstatush and counters not stored here
					endcase
				end
			endcase
		end
	end

	csr_counters u_counters (
		.clk        (clk),
		.reset      (reset),
		.retire     (retire),
		.cy_inhibit (cy_inh),
		.ir_inhibit (ir_inh),
		.wr_en      (cnt_we),
		.wr_sel     (cnt_sel),
		.wr_data    (new_val),
		.mcycle     (mcycle),
		.minstret   (minstret)
	);

endmodule

//--- csr_unit.sv
`timescale 1ns/1ps

module csr_unit import cpu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        req,	// four-phase request
	output logic        ack,
	input  csr_cmd_t    cmd,
	input  csr_op_t     op,
	input  logic [11:0] addr,
	input  logic [31:0] wdata,
	input  logic [31:0] cause,	// mcause layout
	input  logic [31:0] epc,
	input  logic [31:0] tval,
	output logic [31:0] rdata,	// valid while ack high
	output logic        illegal,
	output logic [31:0] redirect_pc,
	input  logic        retire,
	input  logic [2:0]  irq_lines,
	output logic        irq_pending
);

	csr_bus_if bus ();

	csr_access_ctrl u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.ack         (ack),
		.cmd         (cmd),
		.op          (op),
		.addr        (addr),
		.wdata       (wdata),
		.cause       (mcause_t'(cause)),
		.epc         (epc),
		.tval        (tval),
		.rdata       (rdata),
		.illegal     (illegal),
		.redirect_pc (redirect_pc),
		.bus         (bus.ctrl)
	);

	csr_file u_file (
		.clk         (clk),
		.reset       (reset),
		.retire      (retire),
		.irq_lines   (irq_lines),
		.irq_pending (irq_pending),
		.bus         (bus.file)
	);

endmodule

//--- tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit import cpu_pkg::*; ();

	localparam int N_PER_TEST = 60;
	localparam int LIMIT      = 5 * N_PER_TEST * 8 + 200;	// 8 cycles per request plus margin

	logic        clk, reset, req, ack, illegal, retire, irq_pending;
	csr_cmd_t    cmd;
	csr_op_t     op;
	logic [11:0] addr;
	logic [31:0] wdata, cause, epc, tval, rdata, redirect_pc;
	logic [2:0]  irq_lines;
	int          errors, tb_errors, n_req, failed_tests;
	int          cycles = 0;
	integer      seed;

	// eight candidate addresses per test
	logic [11:0] addr_set [40] = '{
		CSR_ADDR_MSCRATCH, CSR_ADDR_MTVEC, CSR_ADDR_MIE, CSR_ADDR_MEPC,
		CSR_ADDR_FCSR, CSR_ADDR_FFLAGS, CSR_ADDR_FRM, CSR_ADDR_MSTATUS,
		CSR_ADDR_MISA, CSR_ADDR_MVENDORID, CSR_ADDR_MARCHID, CSR_ADDR_MIMPID,
		CSR_ADDR_MHARTID, CSR_ADDR_MCONFIGPTR, CSR_ADDR_MSTATUSH, CSR_ADDR_MIP,
		CSR_ADDR_MEPC, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL, CSR_ADDR_MSTATUS,
		CSR_ADDR_MTVEC, CSR_ADDR_MSTATUS, CSR_ADDR_MIE, CSR_ADDR_MSCRATCH,
		CSR_ADDR_MIE, CSR_ADDR_MSTATUS, CSR_ADDR_MIP, CSR_ADDR_MIE,
		CSR_ADDR_MSTATUS, CSR_ADDR_MIP, CSR_ADDR_MIE, CSR_ADDR_MSTATUS,
		CSR_ADDR_MCYCLE, CSR_ADDR_MCYCLEH, CSR_ADDR_MINSTRET, CSR_ADDR_MINSTRETH,
		CSR_ADDR_MCOUNTINHIBIT, CSR_ADDR_MCYCLE, CSR_ADDR_MINSTRET, CSR_ADDR_MCOUNTINHIBIT
	};

	csr_unit u_dut (.*);
	csr_checker u_chk (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// one full four-phase transfer, inputs change on falling edges only
	task automatic issue(input csr_cmd_t c, input csr_op_t o, input logic [11:0] a);
		@(negedge clk);
		cmd       = c;
		op        = o;
		addr      = a;
		wdata     = $random(seed);
		cause     = $random(seed);
		epc       = $random(seed);
		tval      = $random(seed);
		irq_lines = 3'($random(seed));
		req       = 1'b1;
		while (!ack) begin
			@(negedge clk);
			retire = 1'($random(seed));
		end
		req = 1'b0;
		while (ack) begin
			@(negedge clk);
			retire = 1'($random(seed));
		end
		n_req++;
	endtask

	task automatic run_test(input int t, input string name);
		int          e0;
		logic [4:0]  r;
		logic [11:0] a;
		csr_cmd_t    c;
		e0 = errors;
		for (int i = 0; i < N_PER_TEST; i++) begin
			r = 5'($random(seed));
			a = addr_set[(t - 1) * 8 + int'(r[2:0])];
			c = CMD_ACCESS;
			if (t == 2 && r[3])
				a = 12'($random(seed));	// mostly unimplemented space
			if (t == 3 && r[4:3] == 2'd0)
				c = CMD_TRAP;
			if (t == 3 && r[4:3] == 2'd1)
				c = CMD_MRET;
			issue(c, csr_op_t'(2'($random(seed))), a);
		end
		@(negedge clk);	// ack-fall check of the last request
		if (errors != e0)
			failed_tests++;
		$display("test %0d %s: %s", t, name, (errors == e0) ? "pass" : "fail");
	endtask

	initial begin
		seed = 51;
		{req, retire, reset} = 3'b001;
		cmd = CMD_ACCESS;
		op  = CSR_RD;
		{addr, wdata, cause, epc, tval, irq_lines} = '0;
		{tb_errors, n_req, failed_tests} = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		if (ack !== 1'b0) begin
			$display("ack is not low after reset");
			tb_errors++;
		end
		run_test(1, "read-modify-write");
		run_test(2, "read-only and unimplemented");
		run_test(3, "trap and mret");
		run_test(4, "interrupt pending");
		run_test(5, "counters");
		$display("requests %0d, failed tests %0d, errors %0d", n_req, failed_tests,
			errors + tb_errors);
		if (errors + tb_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
cpu_pkg.sv
csr_bus_if.sv
csr_counters.sv
csr_file.sv
csr_access_ctrl.sv
csr_unit.sv
csr_checker.sv
tb_csr_unit.sv
